//--- fill_readout_pkg.sv
/*
 Widths, header field positions and the sequencer state type for fill readout
 The header carries the start burst address in bits 57:35 and the number of
 ADC data bursts in bits 84:64
 The data burst count leaves out the header burst and the checksum burst
*/
package fill_readout_pkg;

	////////////////////
	// Data path widths
	localparam int word_w = 32;
	localparam int burst_w = 128;
	localparam int addr_w = 23;
	localparam int count_w = 21;

	// One DDR3 burst goes out as four transmit words
	localparam int words_per_burst = burst_w / word_w;
	localparam int word_idx_w = $clog2(words_per_burst);

	////////////////////
	// Header fields
	localparam int hdr_addr_lsb = 35;
	localparam int hdr_addr_msb = 57;
	localparam int hdr_count_lsb = 64;
	localparam int hdr_count_msb = 84;

	// Header burst and checksum burst ride along with the ADC data
	localparam int extra_bursts = 2;

	typedef logic [burst_w-1:0] burst_t;
	typedef logic [word_w-1:0] word_t;

	// Sequencer states
	typedef enum logic [3:0] {
		IDLE,
		CHK_FIFO,
		ERROR,
		GET_FIFO_HDR,
		GET_MEM_HDR,
		COMPARE_HDR,
		ECHO_CSN_WAIT,
		ECHO_CSN,
		ECHO_CC_WAIT,
		ECHO_CC,
		GET_BURST,
		XMIT_BURST,
		DONE
	} fill_state_t;

endpackage

//--- fill_burst_if.sv
/*
 Burst hand-over between the fill sequencer and the word serializer
 Only one burst is in flight; the sequencer waits for burst_done before it
 asks the DDR3 for the next one
 abort follows run_sm low and drops an unfinished burst
*/
`timescale 1ns/1ns

interface fill_burst_if;

	// Burst register, written by the sequencer
	fill_readout_pkg::burst_t burst;

	// One-cycle pulse that launches the serializer
	logic start;

	// High while the burst being sent is the checksum burst
	logic last_burst;

	// One-cycle pulse after the fourth word has gone out
	logic burst_done;

	// Transmit ready with the synchronized pause folded in
	logic tready_ok;

	// Run command gone, clear the serializer
	logic abort;

	modport ctrl (
		output burst, start, last_burst, tready_ok, abort,
		input burst_done
	);

	modport ser (
		input burst, start, last_burst, tready_ok, abort,
		output burst_done
	);

endinterface

//--- fill_header_check.sv
/*
 Holds the header taken from the header FIFO and checks it against the
 memory copy of the header
 fifo_data must be valid in the hdr_load cycle (first-word fall-through)
 header_match is valid the cycle after compare and cleared by hdr_load
*/
`timescale 1ns/1ns

module fill_header_check (
	input  logic clk,
	input  logic rst_n,

	// FIFO side
	input  logic hdr_load,
	input  fill_readout_pkg::burst_t fifo_data,

	// Memory side
	input  logic compare,
	input  fill_readout_pkg::burst_t mem_burst,

	// Held header and result
	output fill_readout_pkg::burst_t hdr_fields,
	output logic header_match
);

	////////////////////
	// Header register

	// Loaded once per fill
	// the sequencer reads address and count fields from here
	always_ff @(posedge clk) begin
		if (hdr_load) begin
			hdr_fields <= fifo_data;
		end
	end

	////////////////////
	// Comparator

	// Full 128-bit compare, registered so the wide XOR tree
	// stays out of the sequencer next-state path
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			header_match <= 1'b0;
		end else if (hdr_load) begin
			// Stale result from an earlier fill must not leak through
			header_match <= 1'b0;
		end else if (compare) begin
			header_match <= (mem_burst == hdr_fields);
		end
	end

endmodule

//--- fill_burst_serializer.sv
/*
 Sends one 128-bit burst as four 32-bit words, low word first
 Each word waits for tready_ok, then tx_tvalid is high for exactly one cycle
 A burst takes at least eight cycles from start to burst_done and stretches
 without limit under back-pressure
 tx_tlast comes with the fourth word only when last_burst is high
*/
`timescale 1ns/1ns

module fill_burst_serializer (
	input  logic clk,
	input  logic rst_n,

	fill_burst_if.ser bif,

	output logic tx_tvalid,
	output logic tx_tlast,
	output fill_readout_pkg::word_t tx_data,
	output logic send_fill_data
);

	// Burst in progress
	logic busy;

	// Low in the wait phase, high in the one-cycle valid phase
	logic valid_phase;

	// Which 32-bit slice of the burst is on tx_data
	logic [fill_readout_pkg::word_idx_w-1:0] word_idx;

	logic last_word;

	assign last_word = (word_idx ==
		fill_readout_pkg::word_idx_w'(fill_readout_pkg::words_per_burst - 1));

	////////////////////
	// Word sequencing

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			valid_phase <= 1'b0;
			word_idx <= '0;
			bif.burst_done <= 1'b0;
		end else begin
			bif.burst_done <= 1'b0;
			if (bif.abort) begin
				// Run command dropped mid-burst
				busy <= 1'b0;
				valid_phase <= 1'b0;
			end else if (bif.start) begin
				busy <= 1'b1;
				valid_phase <= 1'b0;
				word_idx <= '0;
			end else if (busy) begin
				if (valid_phase) begin
					// Word accepted, back to waiting
					valid_phase <= 1'b0;
					if (last_word) begin
						busy <= 1'b0;
						bif.burst_done <= 1'b1;
					end else begin
						word_idx <= word_idx + 1'b1;
					end
				end else if (bif.tready_ok) begin
					valid_phase <= 1'b1;
				end
			end
		end
	end

	////////////////////
	// Transmit port

	// valid_phase is only ever set while busy
	assign tx_tvalid = valid_phase;
	assign tx_tlast = valid_phase & last_word & bif.last_burst;

	// Word stays put through its wait and valid phases
	assign tx_data = bif.burst[word_idx * fill_readout_pkg::word_w +: fill_readout_pkg::word_w];

	// Outer mux takes our data from start until burst_done
	assign send_fill_data = bif.start | busy;

endmodule

//--- fill_readout_ctrl.sv
/*
 Fill readout sequencer: header FIFO check, memory header fetch and compare,
 CSN and CC echo strobes, then one DDR3 burst at a time to the serializer
 run_sm is level-held; dropping it returns the sequencer to IDLE
 After sm_done the sequencer stays in IDLE until run_sm goes low
 ddr3_burst_data must be stable once ddr3_burst_rdy is raised
*/
`timescale 1ns/1ns

module fill_readout_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic run_sm,
	input  logic tx_tready,
	input  logic readout_pause,
	input  logic fifo_empty,
	input  logic ddr3_burst_rdy,
	input  fill_readout_pkg::burst_t ddr3_burst_data,
	input  fill_readout_pkg::burst_t hdr_fields,
	input  logic header_match,
	output logic hdr_load,
	output logic compare,
	output logic fifo_rd_en,
	output logic [fill_readout_pkg::addr_w-1:0] ddr3_rd_burst_addr,
	output logic ddr3_rd_one_burst,
	output logic sm_running,
	output logic sm_done,
	output logic echo_tvalid,
	output logic echo_tlast,
	output logic send_csn,
	output logic send_cmd,
	output logic send_inv_cmd,
	fill_burst_if.ctrl bif
);

	fill_readout_pkg::fill_state_t state;
	fill_readout_pkg::fill_state_t next_state;

	logic rdy_sync1;
	logic rdy_sync2;
	logic pause_sync1;
	logic pause_sync2;

	// Set by either error path, picks the inverted CC
	logic error_found;

	// Keeps the sequencer in IDLE after a finished fill
	logic done_hold;

	// Bursts still to be sent
	logic [fill_readout_pkg::count_w-1:0] burst_count;

	////////////////////
	// Synchronizers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdy_sync1 <= 1'b0;
			rdy_sync2 <= 1'b0;
			pause_sync1 <= 1'b0;
			pause_sync2 <= 1'b0;
		end else begin
			rdy_sync1 <= ddr3_burst_rdy;
			rdy_sync2 <= rdy_sync1;
			pause_sync1 <= readout_pause;
			pause_sync2 <= pause_sync1;
		end
	end

	assign bif.tready_ok = tx_tready & ~pause_sync2;
	assign bif.abort = ~run_sm;
	assign bif.last_burst = (burst_count == '0);

	////////////////////
	// Next state
	always_comb begin
		next_state = state;
		case (state)
			fill_readout_pkg::IDLE:
				if (!done_hold) next_state = fill_readout_pkg::CHK_FIFO;
			fill_readout_pkg::CHK_FIFO:
				// Nothing to read out is an error
				next_state = fifo_empty ? fill_readout_pkg::ERROR : fill_readout_pkg::GET_FIFO_HDR;
			fill_readout_pkg::ERROR:
				next_state = fill_readout_pkg::ECHO_CSN_WAIT;
			fill_readout_pkg::GET_FIFO_HDR:
				next_state = fill_readout_pkg::GET_MEM_HDR;
			fill_readout_pkg::GET_MEM_HDR:
				if (rdy_sync2) next_state = fill_readout_pkg::COMPARE_HDR;
			fill_readout_pkg::COMPARE_HDR:
				// First cycle issues compare, second reads the result
				if (!compare) begin
					next_state = header_match ? fill_readout_pkg::ECHO_CSN_WAIT
						: fill_readout_pkg::ERROR;
				end
			fill_readout_pkg::ECHO_CSN_WAIT:
				if (bif.tready_ok) next_state = fill_readout_pkg::ECHO_CSN;
			fill_readout_pkg::ECHO_CSN:
				next_state = fill_readout_pkg::ECHO_CC_WAIT;
			fill_readout_pkg::ECHO_CC_WAIT:
				if (bif.tready_ok) next_state = fill_readout_pkg::ECHO_CC;
			fill_readout_pkg::ECHO_CC:
				// Header burst is already held, so go straight to sending it
				next_state = error_found ? fill_readout_pkg::DONE : fill_readout_pkg::XMIT_BURST;
			fill_readout_pkg::GET_BURST:
				if (rdy_sync2) next_state = fill_readout_pkg::XMIT_BURST;
			fill_readout_pkg::XMIT_BURST:
				if (bif.burst_done) begin
					next_state = bif.last_burst ? fill_readout_pkg::DONE
						: fill_readout_pkg::GET_BURST;
				end
			default:
				next_state = fill_readout_pkg::IDLE;
		endcase
		// Run command gone overrides everything
		if (!run_sm) next_state = fill_readout_pkg::IDLE;
	end

	////////////////////
	// State and registered outputs, decoded from next_state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= fill_readout_pkg::IDLE;
			sm_running <= 1'b0;
			sm_done <= 1'b0;
			hdr_load <= 1'b0;
			fifo_rd_en <= 1'b0;
			compare <= 1'b0;
			ddr3_rd_one_burst <= 1'b0;
			send_csn <= 1'b0;
			send_cmd <= 1'b0;
			send_inv_cmd <= 1'b0;
			echo_tvalid <= 1'b0;
			echo_tlast <= 1'b0;
			bif.start <= 1'b0;
		end else begin
			state <= next_state;
			sm_running <= (next_state != fill_readout_pkg::IDLE);
			sm_done <= (next_state == fill_readout_pkg::DONE);
			// Latch the header and pop it in the same cycle
			hdr_load <= (next_state == fill_readout_pkg::GET_FIFO_HDR);
			fifo_rd_en <= (next_state == fill_readout_pkg::GET_FIFO_HDR);
			compare <= (next_state == fill_readout_pkg::COMPARE_HDR) &&
				(state != fill_readout_pkg::COMPARE_HDR);
			// Header request waits one cycle for the address load
			ddr3_rd_one_burst <= ((next_state == fill_readout_pkg::GET_MEM_HDR) &&
				(state == fill_readout_pkg::GET_MEM_HDR)) ||
				(next_state == fill_readout_pkg::GET_BURST);
			send_csn <= (next_state == fill_readout_pkg::ECHO_CSN_WAIT) ||
				(next_state == fill_readout_pkg::ECHO_CSN);
			send_cmd <= !error_found && ((next_state == fill_readout_pkg::ECHO_CC_WAIT) ||
				(next_state == fill_readout_pkg::ECHO_CC));
			send_inv_cmd <= error_found && ((next_state == fill_readout_pkg::ECHO_CC_WAIT) ||
				(next_state == fill_readout_pkg::ECHO_CC));
			echo_tvalid <= (next_state == fill_readout_pkg::ECHO_CSN) ||
				(next_state == fill_readout_pkg::ECHO_CC);
			// An error reply ends with the CC word
			echo_tlast <= error_found && (next_state == fill_readout_pkg::ECHO_CC);
			bif.start <= (next_state == fill_readout_pkg::XMIT_BURST) &&
				(state != fill_readout_pkg::XMIT_BURST);
		end
	end

	////////////////////
	// Error and done flags
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			error_found <= 1'b0;
			done_hold <= 1'b0;
		end else begin
			if (state == fill_readout_pkg::IDLE) error_found <= 1'b0;
			else if (state == fill_readout_pkg::ERROR) error_found <= 1'b1;
			if (!run_sm) done_hold <= 1'b0;
			else if (state == fill_readout_pkg::DONE) done_hold <= 1'b1;
		end
	end

	////////////////////
	// Address and burst counters
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ddr3_rd_burst_addr <= '0;
			burst_count <= '0;
		end else if (state == fill_readout_pkg::GET_MEM_HDR) begin
			// hdr_fields is steady here, reloading each cycle is harmless
			ddr3_rd_burst_addr <= hdr_fields[fill_readout_pkg::hdr_addr_msb:
				fill_readout_pkg::hdr_addr_lsb];
			burst_count <= hdr_fields[fill_readout_pkg::hdr_count_msb:
				fill_readout_pkg::hdr_count_lsb] +
				fill_readout_pkg::count_w'(fill_readout_pkg::extra_bursts);
		end else if (bif.start) begin
			// Count what is left after the burst now going out
			ddr3_rd_burst_addr <= ddr3_rd_burst_addr + 1'b1;
			burst_count <= burst_count - 1'b1;
		end
	end

	// Capture the burst as soon as the synchronized ready shows up
	always_ff @(posedge clk) begin
		if (rdy_sync2 && ((state == fill_readout_pkg::GET_MEM_HDR) ||
				(state == fill_readout_pkg::GET_BURST))) begin
			bif.burst <= ddr3_burst_data;
		end
	end

endmodule

//--- fill_readout_top.sv
/*
 Fill readout top level with plain ports
 CSN and CC values come from the outer multiplexer, steered by the
 send_* strobes; tx_data only carries fill words
 Echo words and fill words never overlap, so their valid and last are ORed
*/
`timescale 1ns/1ns

module fill_readout_top (
	input  logic clk,
	input  logic rst_n,
	input  logic run_sm,
	input  logic tx_tready,
	input  logic readout_pause,
	input  logic fifo_empty,
	input  fill_readout_pkg::burst_t fifo_data,
	input  logic ddr3_burst_rdy,
	input  fill_readout_pkg::burst_t ddr3_burst_data,
	output logic sm_running,
	output logic sm_done,
	output logic tx_tvalid,
	output logic tx_tlast,
	output fill_readout_pkg::word_t tx_data,
	output logic send_csn,
	output logic send_cmd,
	output logic send_inv_cmd,
	output logic send_fill_data,
	output logic fifo_rd_en,
	output logic [fill_readout_pkg::addr_w-1:0] ddr3_rd_burst_addr,
	output logic ddr3_rd_one_burst
);

	fill_burst_if bif ();

	// Header check hand-shake
	logic hdr_load;
	logic compare;
	logic header_match;
	fill_readout_pkg::burst_t hdr_fields;

	// Two transmit sources
	logic echo_tvalid;
	logic echo_tlast;
	logic ser_tvalid;
	logic ser_tlast;

	fill_readout_ctrl i_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.run_sm(run_sm),
		.tx_tready(tx_tready),
		.readout_pause(readout_pause),
		.fifo_empty(fifo_empty),
		.ddr3_burst_rdy(ddr3_burst_rdy),
		.ddr3_burst_data(ddr3_burst_data),
		.hdr_fields(hdr_fields),
		.header_match(header_match),
		.hdr_load(hdr_load),
		.compare(compare),
		.fifo_rd_en(fifo_rd_en),
		.ddr3_rd_burst_addr(ddr3_rd_burst_addr),
		.ddr3_rd_one_burst(ddr3_rd_one_burst),
		.sm_running(sm_running),
		.sm_done(sm_done),
		.echo_tvalid(echo_tvalid),
		.echo_tlast(echo_tlast),
		.send_csn(send_csn),
		.send_cmd(send_cmd),
		.send_inv_cmd(send_inv_cmd),
		.bif(bif.ctrl)
	);

	// Memory side of the compare is the sequencer's burst register
	fill_header_check i_hdr_check (
		.clk(clk),
		.rst_n(rst_n),
		.hdr_load(hdr_load),
		.fifo_data(fifo_data),
		.compare(compare),
		.mem_burst(bif.burst),
		.hdr_fields(hdr_fields),
		.header_match(header_match)
	);

	fill_burst_serializer i_ser (
		.clk(clk),
		.rst_n(rst_n),
		.bif(bif.ser),
		.tx_tvalid(ser_tvalid),
		.tx_tlast(ser_tlast),
		.tx_data(tx_data),
		.send_fill_data(send_fill_data)
	);

	assign tx_tvalid = echo_tvalid | ser_tvalid;
	assign tx_tlast = echo_tlast | ser_tlast;

endmodule

//--- fill_readout_assert.sv
/*
 Concurrent checks on the fill readout top-level strobes
 Bound into fill_readout_top from the testbench
 All checks are off while rst_n is low
*/
`timescale 1ns/1ns

module fill_readout_assert (
	input  logic clk,
	input  logic rst_n,
	input  logic run_sm,
	input  logic sm_running,
	input  logic sm_done,
	input  logic tx_tvalid,
	input  logic tx_tlast,
	input  logic send_csn,
	input  logic send_cmd,
	input  logic send_inv_cmd,
	input  logic send_fill_data
);

	// Each transmit word is valid for a single cycle
	tvalid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		tx_tvalid |=> !tx_tvalid)
		else $error("tx_tvalid high for more than one cycle");

	// End of fill is a single pulse
	done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		sm_done |=> !sm_done)
		else $error("sm_done high for more than one cycle");

	// Outer mux sees at most one source at a time
	select_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({send_csn, send_cmd, send_inv_cmd, send_fill_data}))
		else $error("more than one send strobe high");

	// Sequencer idle one cycle after the run command goes
	stop_on_run_low: assert property (@(posedge clk) disable iff (!rst_n)
		!run_sm |=> !sm_running)
		else $error("sm_running still high after run_sm went low");

endmodule

//--- fill_readout_checker.sv
/*
 Watches the fill readout outputs and compares every transmit word with a
 reference stream built from the test description
 Outputs are sampled on the falling clock edge
 Fill words are expected low 32 bits first, four per burst
*/
`timescale 1ns/1ns

module fill_readout_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic tx_tready,
	input  logic readout_pause,
	input  logic sm_running,
	input  logic sm_done,
	input  logic tx_tvalid,
	input  logic tx_tlast,
	input  fill_readout_pkg::word_t tx_data,
	input  logic send_csn,
	input  logic send_cmd,
	input  logic send_inv_cmd,
	input  logic send_fill_data,
	input  logic fifo_rd_en,
	input  logic ddr3_rd_one_burst
);

	// One word kind per select strobe
	localparam int kind_csn = 0;
	localparam int kind_cc = 1;
	localparam int kind_inv_cc = 2;
	localparam int kind_fill = 3;

	// Reference stream with the oldest word first
	int exp_kind [$];
	fill_readout_pkg::word_t exp_data [$];
	bit exp_last [$];

	int data_errors = 0;
	int ctrl_errors = 0;

	// Per-test activity counts
	int words_seen = 0;
	int rd_en_cycles = 0;
	int req_count = 0;
	int done_count = 0;
	logic req_prev = 1'b0;

	// Pause delayed as through the two-flop synchronizer
	logic pause_d1 = 1'b0;
	logic pause_d2 = 1'b0;

	// Ready and not paused in the previous cycle
	logic ready_prev = 1'b0;

	task automatic push_word(input int kind, input fill_readout_pkg::word_t data, input bit last);
		exp_kind.push_back(kind);
		exp_data.push_back(data);
		exp_last.push_back(last);
	endtask

	// CSN, then CC; an error reply carries the inverted CC with tlast
	task automatic expect_echo(input bit error_reply);
		push_word(kind_csn, '0, 1'b0);
		if (error_reply) begin
			push_word(kind_inv_cc, '0, 1'b1);
		end else begin
			push_word(kind_cc, '0, 1'b0);
		end
	endtask

	task automatic expect_burst(input fill_readout_pkg::burst_t burst, input bit last_burst);
		int i;
		for (i = 0; i < fill_readout_pkg::words_per_burst; i++) begin
			push_word(kind_fill, burst[i * fill_readout_pkg::word_w +: fill_readout_pkg::word_w],
				last_burst && (i == fill_readout_pkg::words_per_burst - 1));
		end
	endtask

	task automatic drop_expected();
		exp_kind.delete();
		exp_data.delete();
		exp_last.delete();
	endtask

	task automatic start_test();
		drop_expected();
		words_seen = 0;
		rd_en_cycles = 0;
		req_count = 0;
		done_count = 0;
	endtask

	////////////////////
	// Word compare

	task automatic compare_word();
		int kind;
		fill_readout_pkg::word_t data;
		bit last;
		logic [3:0] sel;
		logic [3:0] exp_sel;
		sel = {send_csn, send_cmd, send_inv_cmd, send_fill_data};
		if (exp_kind.size() == 0) begin
			$display("Fail at %0t ns: word %h sent with nothing left in the model", $time, tx_data);
			data_errors++;
		end else begin
			kind = exp_kind.pop_front();
			data = exp_data.pop_front();
			last = exp_last.pop_front();
			// Strobe order csn, cmd, inv_cmd, fill
			exp_sel = 4'b1000 >> kind;
			if (sel !== exp_sel) begin
				$display("Fail at %0t ns: word %0d send strobes %b, expected %b",
					$time, words_seen, sel, exp_sel);
				data_errors++;
			end
			if ((kind == kind_fill) && (tx_data !== data)) begin
				$display("Fail at %0t ns: word %0d data %h, expected %h",
					$time, words_seen, tx_data, data);
				data_errors++;
			end
			if (tx_tlast !== last) begin
				$display("Fail at %0t ns: word %0d tlast %b, expected %b",
					$time, words_seen, tx_tlast, last);
				data_errors++;
			end
		end
		words_seen++;
	endtask

	// Stream drained, one header pop, one request per burst, one done pulse
	task automatic finish_test(input int exp_rd_en, input int exp_req);
		if (exp_kind.size() != 0) begin
			$display("Fail at %0t ns: %0d expected words never sent", $time, exp_kind.size());
			data_errors++;
		end
		if (rd_en_cycles != exp_rd_en) begin
			$display("Fail at %0t ns: fifo_rd_en high %0d cycles, expected %0d",
				$time, rd_en_cycles, exp_rd_en);
			ctrl_errors++;
		end
		if (req_count != exp_req) begin
			$display("Fail at %0t ns: %0d DDR3 requests, expected %0d", $time, req_count, exp_req);
			ctrl_errors++;
		end
		if (done_count != 1) begin
			$display("Fail at %0t ns: %0d sm_done pulses, expected 1", $time, done_count);
			ctrl_errors++;
		end
	endtask

	task automatic check_idle(input string where);
		logic [9:0] ctrl;
		ctrl = {sm_running, sm_done, tx_tvalid, tx_tlast, send_csn, send_cmd,
			send_inv_cmd, send_fill_data, fifo_rd_en, ddr3_rd_one_burst};
		if (ctrl !== '0) begin
			$display("Fail at %0t ns: control outputs %b, expected all low %s", $time, ctrl, where);
			ctrl_errors++;
		end
	endtask

	////////////////////
	// Monitor

	always @(negedge clk) begin
		if (rst_n) begin
			if (fifo_rd_en) rd_en_cycles++;
			// Count a request on its rising edge only
			if (ddr3_rd_one_burst && !req_prev) req_count++;
			if (sm_done) done_count++;
			if (tx_tvalid) begin
				// A word follows a wait cycle with tready high and no pause
				if (!ready_prev) begin
					$display("Fail at %0t ns: word %0d valid without tready_ok the cycle before",
						$time, words_seen);
					ctrl_errors++;
				end
				if (sm_running !== 1'b1) begin
					$display("Fail at %0t ns: word %0d sent with sm_running %b, expected 1",
						$time, words_seen, sm_running);
					ctrl_errors++;
				end
				compare_word();
			end
		end
		req_prev = ddr3_rd_one_burst;
		ready_prev = tx_tready && !pause_d2;
		pause_d2 = pause_d1;
		pause_d1 = readout_pause;
	end

endmodule

//--- tb_fill_readout.sv
/*
 Testbench for the fill readout sequencer
 Models a first-word fall-through header FIFO and a DDR3 burst reader
 with a random answer delay of 0 to 7 cycles
 Random stimulus from $random with a fixed seed
 Each test adds its share to the cycle budget that bounds the run
*/
`timescale 1ns/1ns

module tb_fill_readout;

	logic clk;
	logic rst_n;
	logic run_sm;
	logic tx_tready;
	logic readout_pause;
	logic fifo_empty;
	fill_readout_pkg::burst_t fifo_data;
	logic ddr3_burst_rdy;
	fill_readout_pkg::burst_t ddr3_burst_data;
	logic sm_running;
	logic sm_done;
	logic tx_tvalid;
	logic tx_tlast;
	fill_readout_pkg::word_t tx_data;
	logic send_csn;
	logic send_cmd;
	logic send_inv_cmd;
	logic send_fill_data;
	logic fifo_rd_en;
	logic [fill_readout_pkg::addr_w-1:0] ddr3_rd_burst_addr;
	logic ddr3_rd_one_burst;

	integer seed;
	logic back_pressure;
	int cycle_count = 0;
	int cycle_budget = 200;
	int total_errors;

	// Memory image of the current fill indexed by address minus base
	fill_readout_pkg::burst_t mem_bursts [0:15];
	fill_readout_pkg::burst_t mem_hdr;
	logic [fill_readout_pkg::addr_w-1:0] base_addr;

	fill_readout_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.run_sm(run_sm),
		.tx_tready(tx_tready),
		.readout_pause(readout_pause),
		.fifo_empty(fifo_empty),
		.fifo_data(fifo_data),
		.ddr3_burst_rdy(ddr3_burst_rdy),
		.ddr3_burst_data(ddr3_burst_data),
		.sm_running(sm_running),
		.sm_done(sm_done),
		.tx_tvalid(tx_tvalid),
		.tx_tlast(tx_tlast),
		.tx_data(tx_data),
		.send_csn(send_csn),
		.send_cmd(send_cmd),
		.send_inv_cmd(send_inv_cmd),
		.send_fill_data(send_fill_data),
		.fifo_rd_en(fifo_rd_en),
		.ddr3_rd_burst_addr(ddr3_rd_burst_addr),
		.ddr3_rd_one_burst(ddr3_rd_one_burst)
	);

	fill_readout_checker i_chk (
		.clk(clk),
		.rst_n(rst_n),
		.tx_tready(tx_tready),
		.readout_pause(readout_pause),
		.sm_running(sm_running),
		.sm_done(sm_done),
		.tx_tvalid(tx_tvalid),
		.tx_tlast(tx_tlast),
		.tx_data(tx_data),
		.send_csn(send_csn),
		.send_cmd(send_cmd),
		.send_inv_cmd(send_inv_cmd),
		.send_fill_data(send_fill_data),
		.fifo_rd_en(fifo_rd_en),
		.ddr3_rd_one_burst(ddr3_rd_one_burst)
	);

	bind fill_readout_top fill_readout_assert i_assert (
		.clk(clk),
		.rst_n(rst_n),
		.run_sm(run_sm),
		.sm_running(sm_running),
		.sm_done(sm_done),
		.tx_tvalid(tx_tvalid),
		.tx_tlast(tx_tlast),
		.send_csn(send_csn),
		.send_cmd(send_cmd),
		.send_inv_cmd(send_inv_cmd),
		.send_fill_data(send_fill_data)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	////////////////////
	// Responder models

	// Random tready and pause when back-pressure is on
	always @(posedge clk) begin
		if (back_pressure) begin
			tx_tready <= (($random(seed) & 3) != 0);
			readout_pause <= (($random(seed) & 7) == 0);
		end else begin
			tx_tready <= 1'b1;
			readout_pause <= 1'b0;
		end
	end

	// FIFO holds one header that fifo_rd_en pops
	always @(posedge clk) begin
		if (fifo_rd_en) fifo_empty <= 1'b1;
	end

	// DDR3 reader returns data and ready after a random delay
	// and holds ready until the request drops
	always begin : ddr3_model
		int delay;
		int idx;
		@(posedge clk);
		if (ddr3_rd_one_burst) begin
			idx = ddr3_rd_burst_addr - base_addr;
			delay = $random(seed) & 7;
			repeat (delay) @(posedge clk);
			if (idx == 0) ddr3_burst_data <= mem_hdr;
			else if ((idx > 0) && (idx < 16)) ddr3_burst_data <= mem_bursts[idx];
			ddr3_burst_rdy <= 1'b1;
			while (ddr3_rd_one_burst) @(posedge clk);
			ddr3_burst_rdy <= 1'b0;
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_budget) begin
			$display("Timeout: run still going after %0d clock cycles", cycle_budget);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	////////////////////
	// One fill from setup to idle

	task automatic run_fill(input int n_data, input bit empty, input bit mismatch,
		input bit stress, input bit abort_run);
		fill_readout_pkg::burst_t header;
		int flip;
		int k;
		int words;
		bit error_reply;
		error_reply = empty || mismatch;
		// CSN and CC, then four words per burst
		words = error_reply ? 2 : 2 + fill_readout_pkg::words_per_burst *
			(n_data + fill_readout_pkg::extra_bursts);
		cycle_budget = cycle_budget + 40 * words + 100;

		// Header holds base address and data burst count
		base_addr = fill_readout_pkg::addr_w'($random(seed)) & 23'h0fffff;
		header = {$random(seed), $random(seed), $random(seed), $random(seed)};
		header[fill_readout_pkg::hdr_addr_msb:fill_readout_pkg::hdr_addr_lsb] = base_addr;
		header[fill_readout_pkg::hdr_count_msb:fill_readout_pkg::hdr_count_lsb] =
			fill_readout_pkg::count_w'(n_data);
		mem_bursts[0] = header;
		// Data bursts then checksum burst
		for (k = 1; k <= n_data + 1; k++) begin
			mem_bursts[k] = {$random(seed), $random(seed), $random(seed), $random(seed)};
		end
		mem_hdr = header;
		if (mismatch) begin
			flip = $random(seed) & 127;
			mem_hdr[flip] = ~mem_hdr[flip];
		end

		i_chk.start_test();
		i_chk.expect_echo(error_reply);
		if (!error_reply) begin
			for (k = 0; k <= n_data + 1; k++) begin
				i_chk.expect_burst(mem_bursts[k], k == n_data + 1);
			end
		end

		@(posedge clk);
		back_pressure <= stress;
		fifo_empty <= empty;
		fifo_data <= header;
		@(posedge clk);
		run_sm <= 1'b1;

		if (abort_run) begin
			// Pull run_sm once two bursts are on their way
			while (i_chk.words_seen < 10) @(posedge clk);
			run_sm <= 1'b0;
			@(posedge clk);
			@(negedge clk);
			i_chk.check_idle("one cycle after run_sm dropped");
			i_chk.drop_expected();
		end else begin
			@(posedge clk);
			while (!sm_done) @(posedge clk);
			@(negedge clk);
			i_chk.finish_test(empty ? 0 : 1,
				empty ? 0 : (mismatch ? 1 : n_data + fill_readout_pkg::extra_bursts));
			// Finished fill parks the sequencer while run_sm stays high
			repeat (5) @(posedge clk);
			@(negedge clk);
			i_chk.check_idle("after sm_done with run_sm high");
		end

		@(posedge clk);
		run_sm <= 1'b0;
		back_pressure <= 1'b0;
		repeat (12) @(posedge clk);
		@(negedge clk);
		i_chk.check_idle("with run_sm low");
	endtask

	////////////////////
	// Test sequence

	initial begin
		seed = 2;
		back_pressure = 1'b0;
		rst_n = 1'b0;
		run_sm = 1'b0;
		tx_tready = 1'b0;
		readout_pause = 1'b0;
		fifo_empty = 1'b1;
		fifo_data = '0;
		ddr3_burst_rdy = 1'b0;
		ddr3_burst_data = '0;

		// Reset held for three cycles
		repeat (2) @(posedge clk);
		@(negedge clk);
		i_chk.check_idle("during reset");
		@(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		i_chk.check_idle("after reset with run_sm low");

		// Good fill at full rate
		run_fill(3, 1'b0, 1'b0, 1'b0, 1'b0);
		// Empty header FIFO
		run_fill(2, 1'b1, 1'b0, 1'b0, 1'b0);
		// Memory header differs in one bit
		run_fill(2, 1'b0, 1'b1, 1'b0, 1'b0);
		// Good fill and error reply under random tready and pause
		run_fill(5, 1'b0, 1'b0, 1'b1, 1'b0);
		run_fill(1, 1'b0, 1'b1, 1'b1, 1'b0);
		// run_sm dropped in the middle of the fill data
		run_fill(4, 1'b0, 1'b0, 1'b1, 1'b1);

		total_errors = i_chk.data_errors + i_chk.ctrl_errors;
		$display("Error count: %0d in the word stream, %0d in control outputs",
			i_chk.data_errors, i_chk.ctrl_errors);
		if (total_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

//--- verilog.f
fill_readout_pkg.sv
fill_burst_if.sv
fill_header_check.sv
fill_burst_serializer.sv
fill_readout_ctrl.sv
fill_readout_top.sv
fill_readout_assert.sv
fill_readout_checker.sv
tb_fill_readout.sv
